// File: tb/mmio_vectors.txt
# test op address writeData switches enter testSwitches expReadData expLeds
# op 0 idle, 1 read, 2 write; every field hex; readData checked on reads only
1 1 FFFFFC74 00000000 00 0 0 00000000 000000
1 1 FFFFFC60 00000000 00 0 0 00000000 000000
1 1 FFFFFC64 00000000 00 0 0 00000000 000000
2 2 00000010 DEADBEEF 00 0 0 00000000 000000
2 2 00000020 12345678 00 0 0 00000000 000000
2 1 00000010 00000000 00 0 0 DEADBEEF 000000
2 2 000003FC CAFEF00D 00 0 0 00000000 000000
2 1 00000020 00000000 00 0 0 12345678 000000
2 1 000003FC 00000000 00 0 0 CAFEF00D 000000
2 2 FFFFFC10 55555555 00 0 0 00000000 000000
2 1 00000010 00000000 00 0 0 DEADBEEF 000000
3 0 00000000 00000000 A5 1 0 00000000 000000
3 1 FFFFFC74 00000000 3C 1 0 00000001 000000
3 1 FFFFFC60 00000000 3C 1 0 000000A5 000000
3 0 00000000 00000000 3C 0 0 00000000 000000
3 0 00000000 00000000 C3 2 0 00000000 000000
3 1 FFFFFC74 00000000 11 2 0 00000002 000000
3 1 FFFFFC64 00000000 11 2 0 000000C3 000000
3 0 00000000 00000000 11 0 0 00000000 000000
4 1 FFFFFC74 00000000 7E 0 0 00000000 000000
4 0 00000000 00000000 7E 1 0 00000000 000000
4 1 FFFFFC74 00000000 7E 0 0 00000001 000000
4 1 FFFFFC60 00000000 7E 0 0 0000007E 000000
4 1 FFFFFC74 00000000 99 0 0 00000000 000000
4 1 FFFFFC60 00000000 99 1 0 0000007E 000000
4 1 FFFFFC74 00000000 99 1 0 00000001 000000
4 1 FFFFFC60 00000000 99 0 0 00000099 000000
5 2 FFFFFC80 A1B2C3D4 00 0 0 00000000 000000
5 1 FFFFFC70 00000000 00 0 5 00000005 B2C3D4
5 1 FFFFFC90 00000000 00 0 0 00000000 B2C3D4
5 1 FFFFFC80 00000000 00 0 0 00000000 B2C3D4

// File: vlog.f
+incdir+source
source/mmioPkg.sv
source/addressDecoder.sv
source/operandLatch.sv
source/dataMemory.sv
source/ioPort.sv
source/mmioTop.sv
tb/mmioTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the MMIO testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f vlog.f --top-module mmioTb -Mdir obj_dir -o mmioSim || exit 1
simOutput="$(./obj_dir/mmioSim)"
printf '%s\n' "$simOutput"
grep -qx "TEST PASS" <<< "$simOutput" && echo "Simulation passed" || exit 1

// File: tb/mmioTb.sv
`include "mmio_macros.svh"

module mmioTb;

    timeunit 1ns;
    timeprecision 1ps;

    logic clock;
    logic rst;
    mmioPkg::addr_t address;
    mmioPkg::word_t writeData;
    logic memRead;
    logic memWrite;
    mmioPkg::switch_t switches;
    mmioPkg::test_t testSwitches;
    logic [`MMIO_OPERANDS-1:0] enter;
    mmioPkg::word_t readData;
    mmioPkg::led_t leds;

    // One queue per vector column
    int testQ[$];
    int opQ[$];
    mmioPkg::addr_t addrQ[$];
    mmioPkg::word_t dataQ[$];
    mmioPkg::switch_t switchQ[$];
    logic [`MMIO_OPERANDS-1:0] enterQ[$];
    mmioPkg::test_t testSwQ[$];
    mmioPkg::word_t readQ[$];
    mmioPkg::led_t ledsQ[$];

    int vectorCount;
    int passCount;
    int failCount;
    int testChecks;
    int testErrors;
    bit fileFound;

    mmioTop i_mmioTop (
        .clock        (clock),
        .rst          (rst),
        .address      (address),
        .writeData    (writeData),
        .memRead      (memRead),
        .memWrite     (memWrite),
        .switches     (switches),
        .testSwitches (testSwitches),
        .enter        (enter),
        .readData     (readData),
        .leds         (leds)
    );

    // 8 ns clock
    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    //////////////////////////////
    // Vector file
    //////////////////////////////

    task automatic loadVectors();
        int fd;
        int fieldCount;
        string lineText;
        int tTest;
        int tOp;
        mmioPkg::addr_t tAddr;
        mmioPkg::word_t tData;
        mmioPkg::switch_t tSwitch;
        logic [`MMIO_OPERANDS-1:0] tEnter;
        mmioPkg::test_t tTestSw;
        mmioPkg::word_t tRead;
        mmioPkg::led_t tLeds;
        fd = $fopen("tb/mmio_vectors.txt", "r");
        fileFound = (fd != 0);
        if (fileFound) begin
            while ($fgets(lineText, fd) > 0) begin
                // Column notes start with a hash
                if (lineText.getc(0) != "#") begin
                    fieldCount = $sscanf(lineText, "%h %h %h %h %h %h %h %h %h", tTest, tOp,
                        tAddr, tData, tSwitch, tEnter, tTestSw, tRead, tLeds);
                    if (fieldCount == 9) begin
                        testQ.push_back(tTest);
                        opQ.push_back(tOp);
                        addrQ.push_back(tAddr);
                        dataQ.push_back(tData);
                        switchQ.push_back(tSwitch);
                        enterQ.push_back(tEnter);
                        testSwQ.push_back(tTestSw);
                        readQ.push_back(tRead);
                        ledsQ.push_back(tLeds);
                    end
                end
            end
            $fclose(fd);
        end
        vectorCount = testQ.size();
    endtask

    //////////////////////////////
    // Bus driver and checker
    //////////////////////////////

    // Op 1 is a load, op 2 a store, op 0 an idle cycle
    task automatic applyVector(int n);
        @(posedge clock);
        memRead      <= (opQ[n] == 1);
        memWrite     <= (opQ[n] == 2);
        switches     <= switchQ[n];
        enter        <= enterQ[n];
        testSwitches <= testSwQ[n];
        if (opQ[n] == 0) begin
            // Idle bus carries filler only
            address   <= $urandom();
            writeData <= $urandom();
        end else begin
            address   <= addrQ[n];
            writeData <= dataQ[n];
        end
    endtask

    // Mid cycle once the read path has settled
    task automatic checkVector(int n);
        @(negedge clock);
        if (opQ[n] == 1) begin
            testChecks++;
            if (readData !== readQ[n]) begin
                $display("Fail at %0d ns: test %0d vector %0d readData %h expected %h",
                    $time, testQ[n], n, readData, readQ[n]);
                testErrors++;
            end
        end
        testChecks++;
        if (leds !== ledsQ[n]) begin
            $display("Fail at %0d ns: test %0d vector %0d leds %h expected %h",
                $time, testQ[n], n, leds, ledsQ[n]);
            testErrors++;
        end
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        void'($urandom(95));
        rst          <= 1'b1;
        address      <= '0;
        writeData    <= '0;
        memRead      <= 1'b0;
        memWrite     <= 1'b0;
        switches     <= '0;
        testSwitches <= '0;
        enter        <= '0;
        passCount = 0;
        failCount = 0;
        testChecks = 0;
        testErrors = 0;
        loadVectors();
        if (!fileFound) begin
            $display("Vector file tb/mmio_vectors.txt could not be opened");
            $display("TEST FAIL");
            $finish;
        end else begin
            repeat (3) @(posedge clock);
            rst <= 1'b0;
            for (int n = 0; n < vectorCount; n++) begin
                applyVector(n);
                checkVector(n);
                // Test number changes at its last vector
                if (n == vectorCount - 1 || testQ[n + 1] != testQ[n]) begin
                    $display("Test %0d finished: %0d checks, %0d errors",
                        testQ[n], testChecks, testErrors);
                    passCount += testChecks - testErrors;
                    failCount += testErrors;
                    testChecks = 0;
                    testErrors = 0;
                end
            end
            $display("Checks passed %0d, failed %0d", passCount, failCount);
            if (failCount == 0 && vectorCount > 0) begin
                $display("TEST PASS");
            end else begin
                $display("TEST FAIL");
            end
            $finish;
        end
    end

    // Watchdog of four cycles per vector plus margin
    initial begin
        #1;
        repeat (vectorCount * 4 + 100) @(posedge clock);
        $display("Timeout: the vector run did not end within %0d cycles",
            vectorCount * 4 + 100);
        $display("TEST FAIL");
        $finish;
    end

endmodule

// File: source/mmioTop.sv
`include "mmio_macros.svh"

module mmioTop (
    input  logic                       clock,
    input  logic                       rst,
    input  mmioPkg::addr_t             address,
    input  mmioPkg::word_t             writeData,
    input  logic                       memRead,
    input  logic                       memWrite,
    input  mmioPkg::switch_t           switches,
    input  mmioPkg::test_t             testSwitches,
    input  logic [`MMIO_OPERANDS-1:0]  enter,
    output mmioPkg::word_t             readData,
    output mmioPkg::led_t              leds
);

    mmioPkg::region_t region;
    logic ramWrite;
    logic ledWrite;
    logic [`MMIO_OPERANDS-1:0] operandRead;
    logic [`MMIO_OPERANDS-1:0] fresh;
    mmioPkg::switch_t operandValue [`MMIO_OPERANDS];
    mmioPkg::word_t ramReadData;

    //////////////////////////////
    // Decode
    //////////////////////////////

    addressDecoder i_addressDecoder (
        .address     (address),
        .memRead     (memRead),
        .memWrite    (memWrite),
        .region      (region),
        .ramWrite    (ramWrite),
        .ledWrite    (ledWrite),
        .operandRead (operandRead)
    );

    // One latch per operand button
    for (genvar i = 0; i < `MMIO_OPERANDS; i++) begin : gOperand
        operandLatch i_operandLatch (
            .clock        (clock),
            .rst          (rst),
            .switches     (switches),
            .enter        (enter[i]),
            .operandRead  (operandRead[i]),
            .operandValue (operandValue[i]),
            .fresh        (fresh[i])
        );
    end

    //////////////////////////////
    // Storage and ports
    //////////////////////////////

    dataMemory i_dataMemory (
        .clock       (clock),
        .ramWrite    (ramWrite),
        .address     (address),
        .writeData   (writeData),
        .ramReadData (ramReadData)
    );

    // Aligned operand base so word bits index directly
    ioPort i_ioPort (
        .clock        (clock),
        .rst          (rst),
        .region       (region),
        .operandIndex (address[`MMIO_OPERAND_IDX_W+1:2]),
        .ramReadData  (ramReadData),
        .operandValue (operandValue),
        .fresh        (fresh),
        .testSwitches (testSwitches),
        .writeData    (writeData),
        .ledWrite     (ledWrite),
        .readData     (readData),
        .leds         (leds)
    );

endmodule

// File: source/ioPort.sv
`include "mmio_macros.svh"

module ioPort (
    input  logic                            clock,
    input  logic                            rst,
    input  mmioPkg::region_t                region,
    input  logic [`MMIO_OPERAND_IDX_W-1:0]  operandIndex,
    input  mmioPkg::word_t                  ramReadData,
    input  mmioPkg::switch_t                operandValue [`MMIO_OPERANDS],
    input  logic [`MMIO_OPERANDS-1:0]       fresh,
    input  mmioPkg::test_t                  testSwitches,
    input  mmioPkg::word_t                  writeData,
    input  logic                            ledWrite,
    output mmioPkg::word_t                  readData,
    output mmioPkg::led_t                   leds
);

    //////////////////////////////
    // LED register
    //////////////////////////////

    // Low 24 bits of the store
    always_ff @(posedge clock) begin
        if (rst) begin
            leds <= '0;
        end else if (ledWrite) begin
            leds <= writeData[23:0];
        end
    end

    //////////////////////////////
    // Load result
    //////////////////////////////

    mmioPkg::word_t operandWord;
    mmioPkg::word_t testWord;
    mmioPkg::word_t statusWord;

    // Zero extension of the narrow sources
    assign operandWord = mmioPkg::word_t'(operandValue[operandIndex]);
    assign testWord    = mmioPkg::word_t'(testSwitches);
    // Fresh bit i in status bit i
    assign statusWord  = mmioPkg::word_t'(fresh);

    // Pure address mux
    always_comb begin
        case (region)
            mmioPkg::regionMem: begin
                readData = ramReadData;
            end
            mmioPkg::regionOperand: begin
                readData = operandWord;
            end
            mmioPkg::regionTest: begin
                readData = testWord;
            end
            mmioPkg::regionStatus: begin
                readData = statusWord;
            end
            // LED is write only
            // Unmapped I/O reads as zero
            default: begin
                readData = '0;
            end
        endcase
    end

endmodule

// File: source/dataMemory.sv
`include "mmio_macros.svh"

module dataMemory (
    input  logic           clock,
    input  logic           ramWrite,
    input  mmioPkg::addr_t address,
    input  mmioPkg::word_t writeData,
    output mmioPkg::word_t ramReadData
);

    //////////////////////////////
    // Storage
    //////////////////////////////

    localparam int Words = `MMIO_MEM_WORDS;
    localparam int IndexBits = (Words > 1) ? $clog2(Words) : 1;

    // Word array
    mmioPkg::word_t mem [Words];

    // Word index drops the byte offset
    logic [IndexBits-1:0] wordIndex;

    assign wordIndex = address[IndexBits+1:2];

    //////////////////////////////
    // Access
    //////////////////////////////

    // Read path follows the address
    // Same cycle as the load
    assign ramReadData = mem[wordIndex];

    // Store lands on the edge
    always_ff @(posedge clock) begin
        if (ramWrite) begin
            mem[wordIndex] <= writeData;
        end
    end

    //////////////////////////////
    // Checks
    //////////////////////////////

    // Word stores only
    // No byte or halfword path exists
    assert property (@(posedge clock) ramWrite |-> (address[1:0] == 2'b00))
        else $error("Misaligned store to data memory");

endmodule

// File: source/operandLatch.sv
module operandLatch (
    input  logic             clock,
    input  logic             rst,
    input  mmioPkg::switch_t switches,
    input  logic             enter,
    input  logic             operandRead,
    output mmioPkg::switch_t operandValue,
    output logic             fresh
);

    logic enterPrev;
    logic press;

    // Rising edge of the enter button
    assign press = enter && !enterPrev;

    always_ff @(posedge clock) begin
        if (rst) begin
            enterPrev    <= 1'b0;
            operandValue <= '0;
            fresh        <= 1'b0;
        end else begin
            enterPrev <= enter;
            // Capture once per press
            if (press) begin
                operandValue <= switches;
            end
            // New press beats a read clear
            if (press) begin
                fresh <= 1'b1;
            end else if (operandRead) begin
                fresh <= 1'b0;
            end
        end
    end

    // Every press seen on the button pin leaves the flag set
    assert property (@(posedge clock) disable iff (rst) $rose(enter) |=> fresh);

endmodule

// File: source/addressDecoder.sv
`include "mmio_macros.svh"

module addressDecoder (
    input  mmioPkg::addr_t             address,
    input  logic                       memRead,
    input  logic                       memWrite,
    output mmioPkg::region_t           region,
    output logic                       ramWrite,
    output logic                       ledWrite,
    output logic [`MMIO_OPERANDS-1:0]  operandRead
);

    localparam int IoLowBits = `MMIO_IO_LOW_BITS;
    localparam mmioPkg::addr_t IoBase = `MMIO_IO_BASE;

    logic ioHit;
    logic [`MMIO_OPERANDS-1:0] operandHit;

    // Upper bits select the I/O window
    assign ioHit = (address[31:IoLowBits] == IoBase[31:IoLowBits]);

    // One exact word match per operand
    always_comb begin
        for (int i = 0; i < `MMIO_OPERANDS; i++) begin
            operandHit[i] = (address == mmioPkg::addr_t'(`MMIO_OPERAND_BASE + 4 * i));
        end
    end

    // Name the target
    always_comb begin
        if (!ioHit) begin
            region = mmioPkg::regionMem;
        end else if (address == mmioPkg::addr_t'(`MMIO_LED_ADDR)) begin
            region = mmioPkg::regionLed;
        end else if (|operandHit) begin
            region = mmioPkg::regionOperand;
        end else if (address == mmioPkg::addr_t'(`MMIO_TEST_ADDR)) begin
            region = mmioPkg::regionTest;
        end else if (address == mmioPkg::addr_t'(`MMIO_STATUS_ADDR)) begin
            region = mmioPkg::regionStatus;
        end else begin
            region = mmioPkg::regionUnmapped;
        end
    end

    // Strobes reach one target only
    // I/O writes never land in RAM
    assign ramWrite = memWrite && (region == mmioPkg::regionMem);
    assign ledWrite = memWrite && (region == mmioPkg::regionLed);
    assign operandRead = operandHit & {`MMIO_OPERANDS{memRead}};

    // Strobe sanity on every bus change
    always_comb begin
        assert (!(ramWrite && ledWrite)) else $error("RAM and LED written together");
        assert ($onehot0(operandRead)) else $error("More than one operand read");
    end

endmodule

// File: source/mmioPkg.sv
package mmioPkg;

    //////////////////////////////
    // Bus widths
    //////////////////////////////

    // Data word on the bus
    typedef logic [31:0] word_t;

    // Byte address from the core
    typedef logic [31:0] addr_t;

    //////////////////////////////
    // Board widths
    //////////////////////////////

    // Operand switch bank
    typedef logic [7:0] switch_t;

    // Test mode switches
    typedef logic [2:0] test_t;

    // LED bar
    typedef logic [23:0] led_t;

    // Target of one bus access
    // Decode result only
    typedef enum logic [2:0] {
        regionMem,
        regionLed,
        regionOperand,
        regionTest,
        regionStatus,
        regionUnmapped
    } region_t;

endpackage

// File: source/mmio_macros.svh
`ifndef MMIO_MACROS_SVH
`define MMIO_MACROS_SVH

//////////////////////////////
// Address map
//////////////////////////////

// Upper bits of this word mark the I/O window
`define MMIO_IO_BASE 32'hFFFF_FC00
// Low bits inside the I/O window
`define MMIO_IO_LOW_BITS 10

// Operand i sits at base plus 4*i
// Base stays aligned so the low word bits give the index
`define MMIO_OPERAND_BASE 32'hFFFF_FC60
`define MMIO_TEST_ADDR 32'hFFFF_FC70
`define MMIO_STATUS_ADDR 32'hFFFF_FC74
`define MMIO_LED_ADDR 32'hFFFF_FC80

//////////////////////////////
// Sizes
//////////////////////////////

// Operands A and B by default
`define MMIO_OPERANDS 2
`define MMIO_OPERAND_IDX_W ((`MMIO_OPERANDS > 1) ? $clog2(`MMIO_OPERANDS) : 1)
`define MMIO_MEM_WORDS 256

`endif
